//--- verilog/i2c_bus_pkg.sv
`default_nettype none

package i2c_bus_pkg;

    // Everything the slave needs to know about the two bus lines.
    // All flags are single CLK cycle strobes, registered in the sampler
    typedef struct packed {
        logic scl_rise;   // SCL low to high
        logic scl_fall;   // SCL high to low
        logic sda_rise;   // SDA low to high
        logic sda_fall;   // SDA high to low
        logic start;      // SDA falls with SCL high
        logic stop;       // SDA rises with SCL high
        logic mid_low;    // fixed delay into the SCL low phase
        logic scl;        // synchronized SCL level
        logic sda;        // synchronized SDA level
    } line_ev_t;

endpackage

`default_nettype wire

//--- verilog/i2c_slave_pkg.sv
`default_nettype none

package i2c_slave_pkg;

    typedef logic [7:0] byte_t;       // data or register address
    typedef logic [6:0] dev_addr_t;   // 7-bit device address

    // transaction FSM
    typedef enum logic [2:0] {
        IDLE     = 3'd0,   // no transfer, or waiting for STOP
        CMD_RX   = 3'd1,   // address and R/W from master
        CMD_ACK  = 3'd2,   // slave drives ACK/NACK for the command
        REG_RX   = 3'd3,   // register address byte
        DATA_ACK = 3'd4,   // slave ACK after a received byte
        WR_RX    = 3'd5,   // master writes data bytes
        RD_TX    = 3'd6,   // slave shifts data out
        MSTR_ACK = 3'd7    // master ACK/NACK after a read byte
    } slv_state_e;

    // first byte after START, same bit order as on the wire
    typedef struct packed {
        dev_addr_t dev_addr;
        logic      rw;         // 1 = master reads
    } cmd_t;

    // one write beat towards the user side
    typedef struct packed {
        byte_t reg_addr;
        byte_t data;
    } wr_beat_t;

endpackage

`default_nettype wire

//--- verilog/i2c_line_sampler.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_line_sampler
    import i2c_bus_pkg::*;
#(
    parameter int SYNC_STAGES    = 2,
    parameter int MID_LOW_CYCLES = 4
)
(
    input  logic     CLK,
    input  logic     RST_n,
    input  logic     scl,
    input  logic     sda,
    output line_ev_t ev
);

    localparam int CNT_W = $clog2(MID_LOW_CYCLES + 1);

    // top bit of each pipe holds the previous synchronized level
    logic [SYNC_STAGES:0] scl_pipe;
    logic [SYNC_STAGES:0] sda_pipe;
    logic                 scl_now;
    logic                 scl_prev;
    logic                 sda_now;
    logic                 sda_prev;
    logic [CNT_W-1:0]     low_cnt;   // counts down inside the low phase
    line_ev_t             ev_d;

    assign scl_now  = scl_pipe[SYNC_STAGES-1];
    assign scl_prev = scl_pipe[SYNC_STAGES];
    assign sda_now  = sda_pipe[SYNC_STAGES-1];
    assign sda_prev = sda_pipe[SYNC_STAGES];

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            scl_pipe <= '1;   // idle bus is high
            sda_pipe <= '1;
        end
        else
        begin
            scl_pipe <= {scl_pipe[SYNC_STAGES-1:0], scl};
            sda_pipe <= {sda_pipe[SYNC_STAGES-1:0], sda};
        end
    end

    always_comb
    begin
        ev_d.scl_rise = scl_now & ~scl_prev;
        ev_d.scl_fall = ~scl_now & scl_prev;
        ev_d.sda_rise = sda_now & ~sda_prev;
        ev_d.sda_fall = ~sda_now & sda_prev;
        ev_d.start    = ~sda_now & sda_prev & scl_now & scl_prev;
        ev_d.stop     = sda_now & ~sda_prev & scl_now & scl_prev;
        ev_d.mid_low  = (low_cnt == CNT_W'(1)) & ~scl_now;   // never while SCL is high
        ev_d.scl      = scl_now;
        ev_d.sda      = sda_now;
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            low_cnt <= '0;
            ev      <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
        end
        else
        begin
            ev <= ev_d;   // one extra stage, events lag the pins by SYNC_STAGES+1
            if (ev_d.scl_fall)
                low_cnt <= CNT_W'(MID_LOW_CYCLES);
            else if (ev_d.scl_rise)
                low_cnt <= '0;   // short low phase, drop the pending strobe
            else if (low_cnt != '0)
                low_cnt <= low_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/i2c_shift_unit.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_shift_unit
    import i2c_bus_pkg::*;
    import i2c_slave_pkg::*;
(
    input  logic     CLK,
    input  logic     RST_n,
    input  line_ev_t ev,
    input  logic     rx_shift_en,
    input  logic     tx_load,
    input  logic     tx_shift_en,
    input  logic     cnt_load,
    input  byte_t    tx_load_data,
    output byte_t    rx_byte,
    output logic     byte_done,
    output logic     tx_bit
);

    byte_t      tx_sr;      // bits still to be driven, MSB next
    logic [2:0] bit_cnt;
    logic       bit_tick;   // one bus bit completed

    // master samples on SCL rise in both directions
    assign bit_tick = ev.scl_rise & (rx_shift_en | tx_shift_en) & ~byte_done;

    // first bit of a byte comes straight from the load data
    assign tx_bit = tx_load ? tx_load_data[7] : tx_sr[7];

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end
        else if (cnt_load)
        begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end
        else if (bit_tick)
        begin
            bit_cnt <= bit_cnt + 1'b1;   // wraps back to 0 after bit 8
            if (bit_cnt == 3'd7)
                byte_done <= 1'b1;   // held until the next cnt_load
        end
    end

    // receive side, MSB first
    always_ff @(posedge CLK)
    begin
        if (bit_tick & rx_shift_en)
            rx_byte <= {rx_byte[6:0], ev.sda};
    end

    // transmit side, changes only in the middle of SCL low
    always_ff @(posedge CLK)
    begin
        if (ev.mid_low)
        begin
            if (tx_load)
                tx_sr <= {tx_load_data[6:0], 1'b1};
            else if (tx_shift_en)
                tx_sr <= {tx_sr[6:0], 1'b1};   // fill with released level
        end
    end

endmodule

`default_nettype wire

//--- verilog/i2c_slave_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_fsm
    import i2c_bus_pkg::*;
    import i2c_slave_pkg::*;
(
    input  logic     CLK,
    input  logic     RST_n,
    input  line_ev_t ev,
    input  byte_t    rx_byte,
    input  logic     byte_done,
    input  logic     tx_bit,
    input  logic     nack,
    input  byte_t    rd_data,
    output logic     rx_shift_en,
    output logic     tx_load,
    output logic     tx_shift_en,
    output logic     cnt_load,
    output byte_t    tx_load_data,
    output logic     sda_out,
    output logic     busy,
    output logic     wr_valid,
    output logic     rd_adv,
    output cmd_t     cmd,
    output byte_t    reg_addr,
    output wr_beat_t wr_beat
);

    slv_state_e state;
    logic       done_q;     // byte_done delayed, for edge detect
    logic       byte_new;   // first cycle of byte_done
    logic       nack_q;     // user decision for this transaction
    logic       wr_take;    // data byte complete in a write burst

    assign byte_new = byte_done & ~done_q;
    assign wr_take  = (state == WR_RX) & byte_new & ~ev.stop;

    always_comb
    begin
        rx_shift_en  = (state == CMD_RX) | (state == REG_RX) | (state == WR_RX);
        tx_shift_en  = (state == RD_TX);
        // read data goes out after an accepted read command or a master ACK
        tx_load      = (state == MSTR_ACK) | ((state == CMD_ACK) & cmd.rw & ~nack_q);
        cnt_load     = ev.start | (ev.mid_low & byte_done);   // new byte starts
        tx_load_data = rd_data;
    end

    always_ff @(posedge CLK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state    <= IDLE;
            done_q   <= 1'b0;
            nack_q   <= 1'b1;
            sda_out  <= 1'b1;
            busy     <= 1'b0;
            wr_valid <= 1'b0;
            rd_adv   <= 1'b0;
            cmd      <= '0;
            reg_addr <= '0;
        end
        else
        begin
            done_q   <= byte_done;
            wr_valid <= 1'b0;   // strobes
            rd_adv   <= 1'b0;
            if (ev.stop)
            begin
                state   <= IDLE;   // from any state, ends the transaction
                sda_out <= 1'b1;
                busy    <= 1'b0;
            end
            else
            begin
                case (state)
                    IDLE:
                    begin
                        if (ev.start)
                        begin
                            busy  <= 1'b1;
                            state <= CMD_RX;
                        end
                    end
                    CMD_RX:
                    begin
                        if (byte_new)
                            cmd <= cmd_t'(rx_byte);   // user answers through nack
                        if (ev.mid_low & byte_done)
                        begin
                            nack_q  <= nack;
                            sda_out <= nack;
                            state   <= CMD_ACK;
                        end
                    end
                    CMD_ACK:
                    begin
                        if (ev.mid_low)
                        begin
                            if (nack_q)
                            begin
                                sda_out <= 1'b1;
                                state   <= IDLE;   // busy stays up until STOP
                            end
                            else if (cmd.rw)
                            begin
                                sda_out <= tx_bit;   // MSB of first read byte
                                state   <= RD_TX;
                            end
                            else
                            begin
                                sda_out <= 1'b1;
                                state   <= REG_RX;
                            end
                        end
                    end
                    REG_RX:
                    begin
                        if (byte_new)
                            reg_addr <= rx_byte;
                        if (ev.mid_low & byte_done)
                        begin
                            sda_out <= nack_q;
                            state   <= DATA_ACK;
                        end
                    end
                    DATA_ACK:
                    begin
                        if (ev.mid_low)
                        begin
                            sda_out <= 1'b1;   // release for master data
                            state   <= WR_RX;
                        end
                    end
                    WR_RX:
                    begin
                        if (wr_take)
                        begin
                            wr_valid <= 1'b1;
                            reg_addr <= reg_addr + 1'b1;   // wraps at 8'hff
                        end
                        if (ev.mid_low & byte_done)
                        begin
                            sda_out <= nack_q;
                            state   <= DATA_ACK;
                        end
                    end
                    RD_TX:
                    begin
                        if (ev.mid_low)
                        begin
                            if (byte_done)
                            begin
                                sda_out <= 1'b1;   // master drives the ACK bit
                                state   <= MSTR_ACK;
                            end
                            else
                                sda_out <= tx_bit;
                        end
                    end
                    MSTR_ACK:
                    begin
                        if (ev.scl_rise)
                        begin
                            if (ev.sda)
                                state <= IDLE;   // NACK, last byte read
                            else
                            begin
                                reg_addr <= reg_addr + 1'b1;
                                rd_adv   <= 1'b1;
                            end
                        end
                        else if (ev.mid_low)
                        begin
                            sda_out <= tx_bit;
                            state   <= RD_TX;
                        end
                    end
                    default:
                    begin
                        sda_out <= 1'b1;
                        state   <= IDLE;
                    end
                endcase
            end
        end
    end

    // beat carries the address before the increment
    always_ff @(posedge CLK)
    begin
        if (wr_take)
            wr_beat <= '{reg_addr: reg_addr, data: rx_byte};
    end

endmodule

`default_nettype wire

//--- verilog/i2c_slave_top.sv
`timescale 1ns/100ps
`default_nettype none

module i2c_slave_top
    import i2c_bus_pkg::*;
    import i2c_slave_pkg::*;
#(
    parameter int SYNC_STAGES    = 2,
    parameter int MID_LOW_CYCLES = 4
)
(
    input  logic     CLK,
    input  logic     RST_n,
    input  logic     scl,
    input  logic     sda,        // resolved bus level
    output logic     sda_out,    // 0 pulls SDA low
    input  logic     nack,
    output cmd_t     cmd,
    output byte_t    reg_addr,
    output wr_beat_t wr_beat,
    output logic     wr_valid,
    input  byte_t    rd_data,
    output logic     rd_adv,
    output logic     busy
);

    line_ev_t ev;
    byte_t    rx_byte;
    byte_t    tx_load_data;
    logic     byte_done;
    logic     tx_bit;
    logic     rx_shift_en;
    logic     tx_load;
    logic     tx_shift_en;
    logic     cnt_load;

    i2c_line_sampler #(
        .SYNC_STAGES    (SYNC_STAGES),
        .MID_LOW_CYCLES (MID_LOW_CYCLES)
    ) sampler0 (
        .CLK   (CLK),
        .RST_n (RST_n),
        .scl   (scl),
        .sda   (sda),
        .ev    (ev)
    );

    i2c_shift_unit shift0 (
        .CLK          (CLK),
        .RST_n        (RST_n),
        .ev           (ev),
        .rx_shift_en  (rx_shift_en),
        .tx_load      (tx_load),
        .tx_shift_en  (tx_shift_en),
        .cnt_load     (cnt_load),
        .tx_load_data (tx_load_data),
        .rx_byte      (rx_byte),
        .byte_done    (byte_done),
        .tx_bit       (tx_bit)
    );

    i2c_slave_fsm fsm0 (
        .CLK          (CLK),
        .RST_n        (RST_n),
        .ev           (ev),
        .rx_byte      (rx_byte),
        .byte_done    (byte_done),
        .tx_bit       (tx_bit),
        .nack         (nack),
        .rd_data      (rd_data),
        .rx_shift_en  (rx_shift_en),
        .tx_load      (tx_load),
        .tx_shift_en  (tx_shift_en),
        .cnt_load     (cnt_load),
        .tx_load_data (tx_load_data),
        .sda_out      (sda_out),
        .busy         (busy),
        .wr_valid     (wr_valid),
        .rd_adv       (rd_adv),
        .cmd          (cmd),
        .reg_addr     (reg_addr),
        .wr_beat      (wr_beat)
    );

endmodule

`default_nettype wire

//--- dv/tb_i2c_slave.sv
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_slave
    import i2c_slave_pkg::*;
();

    localparam int        PHASE    = 8;       // CLK cycles per SCL phase
    localparam int        WAIT_MAX = 40;      // bound for every busy wait
    localparam dev_addr_t OWN_ADDR = 7'h2c;   // the only address the user side ACKs

    logic        CLK;
    logic        RST_n;
    logic        scl;
    logic        master_sda;
    logic        sda;
    logic        sda_out;
    logic        nack;
    cmd_t        cmd;
    byte_t       reg_addr;
    wr_beat_t    wr_beat;
    logic        wr_valid;
    byte_t       rd_data;
    logic        rd_adv;
    logic        busy;

    wr_beat_t    beat_q[$];        // every write beat seen on the user side
    int          rd_adv_cnt = 0;
    int          err_cnt;
    int          err_at_start;
    int          test_cnt;
    int          test_fail;
    logic [31:0] lfsr;

    assign sda     = master_sda & sda_out;   // wired-AND bus
    assign rd_data = reg_addr ^ 8'h5a;       // user-side register file model
    assign nack    = (cmd.dev_addr != OWN_ADDR);

    i2c_slave_top #(
        .SYNC_STAGES    (2),
        .MID_LOW_CYCLES (4)
    ) dut0 (
        .CLK      (CLK),
        .RST_n    (RST_n),
        .scl      (scl),
        .sda      (sda),
        .sda_out  (sda_out),
        .nack     (nack),
        .cmd      (cmd),
        .reg_addr (reg_addr),
        .wr_beat  (wr_beat),
        .wr_valid (wr_valid),
        .rd_data  (rd_data),
        .rd_adv   (rd_adv),
        .busy     (busy)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // user-side strobes are registered, so look at them mid-cycle
    always @(negedge CLK)
    begin
        if (wr_valid)
            beat_q.push_back(wr_beat);
        if (rd_adv)
            rd_adv_cnt++;
    end

    task automatic tick(input int n);
        repeat (n) @(posedge CLK);
        #1;   // inputs change just after the edge
    endtask

    task automatic flag_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        err_cnt++;
    endtask

    task automatic flag_timeout(input string msg);
        $display("timeout, %s", msg);
        err_cnt++;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < WAIT_MAX)
        begin
            tick(1);
            n++;
        end
        if (busy !== level)
            flag_timeout($sformatf("busy did not go to %0b within %0d cycles", level, WAIT_MAX));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic random_byte(output byte_t b);
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    // entered with SCL just pulled low
    task automatic clock_bit(input logic b, output logic r);
        tick(1);
        master_sda = b;
        tick(PHASE - 1);
        scl = 1'b1;
        tick(PHASE - 1);
        r = sda;   // late in the high phase
        tick(1);
        scl = 1'b0;
    endtask

    task automatic i2c_start();
        tick(PHASE);
        master_sda = 1'b0;
        tick(PHASE);
        scl = 1'b0;
    endtask

    task automatic i2c_stop();
        tick(1);
        master_sda = 1'b0;
        tick(PHASE - 1);
        scl = 1'b1;
        tick(PHASE);
        master_sda = 1'b1;
        tick(PHASE);
    endtask

    task automatic send_byte(input byte_t b, output logic ack);
        logic r;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], r);
        clock_bit(1'b1, ack);   // release for the slave ACK
    endtask

    task automatic recv_byte(input logic nak, output byte_t b);
        logic r;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, r);
            b[i] = r;
        end
        clock_bit(nak, r);
    endtask

    task automatic begin_test();
        err_at_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == err_at_start)
            $display("test %s: ok", name);
        else
        begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_at_start);
        end
    endtask

    // full write transaction, then compare the user-side beats
    task automatic write_burst(input byte_t start_reg, input int count);
        byte_t    sent[$];
        byte_t    d;
        byte_t    exp_reg;
        logic     ack;
        int       base;
        wr_beat_t got;
        base = beat_q.size();
        i2c_start();
        wait_busy(1'b1);
        send_byte({OWN_ADDR, 1'b0}, ack);
        if (ack !== 1'b0)
            flag_error("write command not ACKed");
        if (cmd !== {OWN_ADDR, 1'b0})
            flag_error($sformatf("cmd is %h after write command", cmd));
        send_byte(start_reg, ack);
        if (ack !== 1'b0)
            flag_error("register address not ACKed");
        if (reg_addr !== start_reg)
            flag_error($sformatf("reg_addr is %h, expected %h", reg_addr, start_reg));
        for (int i = 0; i < count; i++)
        begin
            random_byte(d);
            sent.push_back(d);
            send_byte(d, ack);
            if (ack !== 1'b0)
                flag_error($sformatf("data byte %0d not ACKed", i));
        end
        i2c_stop();
        wait_busy(1'b0);
        if (beat_q.size() - base != count)
            flag_error($sformatf("%0d write beats, expected %0d", beat_q.size() - base, count));
        else
        begin
            exp_reg = start_reg;
            for (int i = 0; i < count; i++)
            begin
                got = beat_q[base + i];
                if (got.reg_addr !== exp_reg || got.data !== sent[i])
                    flag_error($sformatf("beat %0d is %h/%h, expected %h/%h", i,
                        got.reg_addr, got.data, exp_reg, sent[i]));
                exp_reg = exp_reg + 8'd1;
            end
        end
    endtask

    task automatic test_reset();
        begin_test();
        if (sda_out !== 1'b1)
            flag_error("sda_out not released after reset");
        if (busy !== 1'b0)
            flag_error("busy set after reset");
        if (wr_valid !== 1'b0)
            flag_error("wr_valid set after reset");
        if (rd_adv !== 1'b0)
            flag_error("rd_adv set after reset");
        end_test("reset");
    endtask

    task automatic test_busy();
        logic ack;
        int   base;
        begin_test();
        base = beat_q.size();
        if (busy !== 1'b0)
            flag_error("busy set before START");
        i2c_start();
        wait_busy(1'b1);
        send_byte({OWN_ADDR, 1'b0}, ack);
        if (ack !== 1'b0)
            flag_error("command to 0x2c not ACKed");
        i2c_stop();
        wait_busy(1'b0);
        i2c_start();
        wait_busy(1'b1);
        send_byte({7'h13, 1'b0}, ack);
        if (ack !== 1'b1)
            flag_error("command to 0x13 ACKed");
        send_byte(8'h10, ack);   // slave ignores the rest
        if (ack !== 1'b1)
            flag_error("byte after NACKed command was ACKed");
        send_byte(8'h3c, ack);
        if (ack !== 1'b1)
            flag_error("data byte after NACKed command was ACKed");
        i2c_stop();
        wait_busy(1'b0);
        if (beat_q.size() != base)
            flag_error("write beat after a NACKed command");
        end_test("busy window");
    endtask

    task automatic test_write();
        begin_test();
        write_burst(8'h10, 4);
        end_test("write burst");
    endtask

    task automatic test_read();
        byte_t got;
        byte_t exp_reg;
        logic  ack;
        int    adv_base;
        begin_test();
        write_burst(8'hfe, 0);   // register address only
        adv_base = rd_adv_cnt;
        i2c_start();
        wait_busy(1'b1);
        send_byte({OWN_ADDR, 1'b1}, ack);
        if (ack !== 1'b0)
            flag_error("read command not ACKed");
        if (cmd !== {OWN_ADDR, 1'b1})
            flag_error($sformatf("cmd is %h after read command", cmd));
        exp_reg = 8'hfe;
        for (int i = 0; i < 3; i++)
        begin
            recv_byte(i == 2, got);   // NACK ends the burst
            if (got !== (exp_reg ^ 8'h5a))
                flag_error($sformatf("read byte %0d is %h, expected %h", i, got,
                    exp_reg ^ 8'h5a));
            exp_reg = exp_reg + 8'd1;
        end
        i2c_stop();
        wait_busy(1'b0);
        if (rd_adv_cnt - adv_base != 2)
            flag_error($sformatf("%0d rd_adv pulses, expected 2", rd_adv_cnt - adv_base));
        end_test("read burst");
    endtask

    task automatic test_recovery();
        byte_t part;
        logic  ack;
        logic  r;
        begin_test();
        part = 8'ha5;
        i2c_start();
        wait_busy(1'b1);
        send_byte({OWN_ADDR, 1'b0}, ack);
        if (ack !== 1'b0)
            flag_error("command not ACKed before abort");
        for (int i = 7; i >= 4; i--)
            clock_bit(part[i], r);   // half a register byte
        i2c_stop();
        wait_busy(1'b0);
        write_burst(8'h10, 4);
        end_test("recovery");
    endtask

    initial
    begin
        RST_n      = 1'b0;
        scl        = 1'b1;
        master_sda = 1'b1;
        lfsr       = 32'hd01c3c4f;
        err_cnt    = 0;
        test_cnt   = 0;
        test_fail  = 0;
        tick(4);
        RST_n = 1'b1;
        tick(2);
        test_reset();
        test_busy();
        test_write();
        test_read();
        test_recovery();
        $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/i2c_bus_pkg.sv
verilog/i2c_slave_pkg.sv
verilog/i2c_line_sampler.sv
verilog/i2c_shift_unit.sv
verilog/i2c_slave_fsm.sv
verilog/i2c_slave_top.sv
dv/tb_i2c_slave.sv

//--- run_sim.sh
#!/bin/sh
# build and run the I2C slave testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_i2c_slave \
    -f project.f -o tb_i2c_slave || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_i2c_slave)" ; printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TEST PASS" && exit 0 || exit 1
